/* Bender.yml */
package:
  name: execute_stage

sources:
  - hdl/execPkg.sv
  - hdl/unitRespIf.sv
  - hdl/aluBranchUnit.sv
  - hdl/mulDivUnit.sv
  - hdl/resultMerge.sv
  - hdl/executeTop.sv
  - target: simulation
    files:
      - sim/executeTop_props.sv
      - sim/executeTb.sv

/* hdl/aluBranchUnit.sv */
// ============================================================
// single-cycle ALU and branch unit with a one-entry response
// inValid must already include the stage handshake
// ============================================================
module aluBranchUnit #(
    parameter int xLen = execPkg::xLen
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    input  execPkg::execOp        inOp,
    input  execPkg::branchType    inBranch,
    input  logic                  inUseImm,
    input  logic [xLen-1:0]       inPc,
    input  logic [xLen-1:0]       inSrc1,
    input  logic [xLen-1:0]       inSrc2,
    input  logic [xLen-1:0]       inImm,
    output logic                  unitReady,
    unitRespIf.unit               resp
);

    localparam int shW = $clog2(xLen);

    logic            accept;
    logic [xLen-1:0] op2;
    logic [shW-1:0]  shamt;
    logic [xLen-1:0] aluResult;
    logic            cmpHolds;
    logic            taken;
    logic [xLen-1:0] target;

    // slot free or draining this cycle
    assign unitReady = !resp.valid || resp.ready;
    assign accept = inValid && unitReady && !execPkg::isMulDiv(inOp);

    always_comb begin
        op2 = inUseImm ? inImm : inSrc2;
        shamt = op2[shW-1:0];
        unique case (inOp)
            execPkg::opAdd:    aluResult = inSrc1 + op2;
            execPkg::opSub:    aluResult = inSrc1 - op2;
            execPkg::opSll:    aluResult = inSrc1 << shamt;
            execPkg::opSlt:    aluResult = {{(xLen-1){1'b0}}, $signed(inSrc1) < $signed(op2)};
            execPkg::opSltu:   aluResult = {{(xLen-1){1'b0}}, inSrc1 < op2};
            execPkg::opXor:    aluResult = inSrc1 ^ op2;
            execPkg::opSrl:    aluResult = inSrc1 >> shamt;
            execPkg::opSra:    aluResult = $signed(inSrc1) >>> shamt;
            execPkg::opOr:     aluResult = inSrc1 | op2;
            execPkg::opAnd:    aluResult = inSrc1 & op2;
            execPkg::opClear1: aluResult = inSrc1 & ~op2;
            execPkg::opClear2: aluResult = ~inSrc1 & op2;
            default:           aluResult = '0;
        endcase
    end

    // branch compare always uses the register sources
    always_comb begin
        unique case (inBranch)
            execPkg::brEq:     cmpHolds = inSrc1 == inSrc2;
            execPkg::brNe:     cmpHolds = inSrc1 != inSrc2;
            execPkg::brLt:     cmpHolds = $signed(inSrc1) < $signed(inSrc2);
            execPkg::brGe:     cmpHolds = $signed(inSrc1) >= $signed(inSrc2);
            execPkg::brLtu:    cmpHolds = inSrc1 < inSrc2;
            execPkg::brGeu:    cmpHolds = inSrc1 >= inSrc2;
            execPkg::brAlways: cmpHolds = 1'b1;
            default:           cmpHolds = 1'b0;
        endcase
        taken = (inBranch != execPkg::brNone) && cmpHolds;
        target = taken ? inPc + inImm : inPc + xLen'(execPkg::insnSize);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resp.valid <= 1'b0;
        end else if (accept) begin
            resp.valid <= 1'b1;
        end else if (resp.ready) begin
            resp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp.data <= aluResult;
            resp.taken <= taken;
            resp.target <= target;
        end
    end

endmodule

/* hdl/execPkg.sv */
// ============================================================
// shared types of the RV32 integer execute stage
// op codes 16 and up form the multiply/divide group
// ============================================================
package execPkg;

    // data and pc width
    parameter int xLen = 32;

    // pc step of one instruction
    parameter int insnSize = 4;

    parameter int opWidth = 5;
    parameter int brWidth = 3;

    typedef enum logic [opWidth-1:0] {
        opAdd    = 5'd0,
        opSub    = 5'd1,
        opSll    = 5'd2,
        opSlt    = 5'd3,
        opSltu   = 5'd4,
        opXor    = 5'd5,
        opSrl    = 5'd6,
        opSra    = 5'd7,
        opOr     = 5'd8,
        opAnd    = 5'd9,
        // src1 & ~src2
        opClear1 = 5'd10,
        // ~src1 & src2
        opClear2 = 5'd11,
        // RV32M group
        opMul    = 5'd16,
        opMulh   = 5'd17,
        opMulhsu = 5'd18,
        opMulhu  = 5'd19,
        opDiv    = 5'd20,
        opDivu   = 5'd21,
        opRem    = 5'd22,
        opRemu   = 5'd23
    } execOp;

    typedef enum logic [brWidth-1:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu,
        brAlways
    } branchType;

    typedef enum logic [1:0] {
        sIdle,
        sBusy,
        sDone
    } mulDivState;

    function automatic logic isMulDiv(execOp op);
        return op inside {
            opMul, opMulh, opMulhsu, opMulhu,
            opDiv, opDivu, opRem, opRemu
        };
    endfunction

endpackage

/* hdl/executeTop.sv */
// ============================================================
// integer execute stage, valid/ready in and out
// one mul/div op in flight blocks all issue until it leaves
// ============================================================
module executeTop #(
    parameter int xLen = execPkg::xLen
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    output logic               inReady,
    input  execPkg::execOp     inOp,
    input  execPkg::branchType inBranch,
    input  logic               inUseImm,
    input  logic [xLen-1:0]    inPc,
    input  logic [xLen-1:0]    inSrc1,
    input  logic [xLen-1:0]    inSrc2,
    input  logic [xLen-1:0]    inImm,
    output logic               outValid,
    input  logic               outReady,
    output logic [xLen-1:0]    outResult,
    output logic               outBranchTaken,
    output logic [xLen-1:0]    outNextPc
);

    logic aluReady;
    logic mulDivReady;

    unitRespIf #(.xLen(xLen)) aluResp ();
    unitRespIf #(.xLen(xLen)) mulDivResp ();

    // units only see inputs that actually transfer
    aluBranchUnit #(.xLen(xLen)) aluUnit (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid && inReady),
        .inOp      (inOp),
        .inBranch  (inBranch),
        .inUseImm  (inUseImm),
        .inPc      (inPc),
        .inSrc1    (inSrc1),
        .inSrc2    (inSrc2),
        .inImm     (inImm),
        .unitReady (aluReady),
        .resp      (aluResp)
    );

    mulDivUnit #(.xLen(xLen)) mulDiv (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid && inReady),
        .inOp      (inOp),
        .inPc      (inPc),
        .inSrc1    (inSrc1),
        .inSrc2    (inSrc2),
        .unitReady (mulDivReady),
        .resp      (mulDivResp)
    );

    resultMerge #(.xLen(xLen)) merge (
        .clk            (clk),
        .arstN          (arstN),
        .outReady       (outReady),
        .inReady        (inReady),
        .outValid       (outValid),
        .outResult      (outResult),
        .outBranchTaken (outBranchTaken),
        .outNextPc      (outNextPc),
        .aluReady       (aluReady),
        .mulDivReady    (mulDivReady),
        .aluResp        (aluResp),
        .mulDivResp     (mulDivResp)
    );

endmodule

/* hdl/mulDivUnit.sv */
// ============================================================
// iterative RV32M unit, one op at a time, xLen steps per op
// shift-add multiply and restoring divide on magnitudes
// ============================================================
module mulDivUnit #(
    parameter int xLen = execPkg::xLen
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    input  execPkg::execOp        inOp,
    input  logic [xLen-1:0]       inPc,
    input  logic [xLen-1:0]       inSrc1,
    input  logic [xLen-1:0]       inSrc2,
    output logic                  unitReady,
    unitRespIf.unit               resp
);

    localparam int cntW = $clog2(xLen);

    execPkg::mulDivState state;
    logic [cntW-1:0]     count;
    execPkg::execOp      opReg;
    logic [xLen-1:0]     pcReg;
    logic [xLen-1:0]     operandB;
    // multiply: {product hi, multiplier}, divide: {remainder, quotient}
    logic [2*xLen-1:0]   acc;
    logic                negRes;
    logic                negRem;
    logic                divZero;
    logic                isDivReg;

    logic                accept;
    logic                src1Signed;
    logic                src2Signed;
    logic                negA;
    logic                negB;
    logic [xLen-1:0]     magA;
    logic [xLen-1:0]     magB;
    logic [xLen:0]       addSum;
    logic [xLen:0]       remShift;
    logic [xLen:0]       remDiff;
    logic [2*xLen-1:0]   prodFinal;
    logic [xLen-1:0]     quoFinal;
    logic [xLen-1:0]     remFinal;

    assign unitReady = (state == execPkg::sIdle);
    assign accept = inValid && unitReady && execPkg::isMulDiv(inOp);

    always_comb begin
        src1Signed = inOp inside {execPkg::opMulh, execPkg::opMulhsu,
                                  execPkg::opDiv, execPkg::opRem};
        src2Signed = inOp inside {execPkg::opMulh, execPkg::opDiv, execPkg::opRem};
        negA = src1Signed && inSrc1[xLen-1];
        negB = src2Signed && inSrc2[xLen-1];
        magA = negA ? -inSrc1 : inSrc1;
        magB = negB ? -inSrc2 : inSrc2;
    end

    // one step of either algorithm
    always_comb begin
        addSum = {1'b0, acc[2*xLen-1:xLen]} + (acc[0] ? {1'b0, operandB} : '0);
        remShift = acc[2*xLen-1:xLen-1];
        remDiff = remShift - {1'b0, operandB};
    end

    // sign fix-up; min / -1 already comes out right on magnitudes
    always_comb begin
        prodFinal = negRes ? -acc : acc;
        quoFinal = negRes ? -acc[xLen-1:0] : acc[xLen-1:0];
        remFinal = negRem ? -acc[2*xLen-1:xLen] : acc[2*xLen-1:xLen];
        unique case (opReg)
            execPkg::opMul:   resp.data = prodFinal[xLen-1:0];
            execPkg::opMulh,
            execPkg::opMulhsu,
            execPkg::opMulhu: resp.data = prodFinal[2*xLen-1:xLen];
            execPkg::opDiv,
            execPkg::opDivu:  resp.data = divZero ? '1 : quoFinal;
            execPkg::opRem,
            execPkg::opRemu:  resp.data = remFinal;
            default:          resp.data = '0;
        endcase
    end

    assign resp.valid = (state == execPkg::sDone);
    assign resp.taken = 1'b0;
    assign resp.target = pcReg + xLen'(execPkg::insnSize);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= execPkg::sIdle;
            count <= '0;
        end else begin
            unique case (state)
                execPkg::sIdle: begin
                    if (accept) begin
                        state <= execPkg::sBusy;
                        count <= '0;
                    end
                end
                execPkg::sBusy: begin
                    count <= count + 1'b1;
                    if (count == cntW'(xLen - 1)) begin
                        state <= execPkg::sDone;
                    end
                end
                execPkg::sDone: begin
                    if (resp.ready) begin
                        state <= execPkg::sIdle;
                    end
                end
                default: state <= execPkg::sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opReg <= inOp;
            pcReg <= inPc;
            operandB <= magB;
            acc <= {{xLen{1'b0}}, magA};
            negRes <= negA ^ negB;
            negRem <= negA;
            divZero <= (inSrc2 == '0);
            isDivReg <= inOp inside {execPkg::opDiv, execPkg::opDivu,
                                     execPkg::opRem, execPkg::opRemu};
        end else if (state == execPkg::sBusy) begin
            if (!isDivReg) begin
                acc <= {addSum, acc[xLen-1:1]};
            end else if (remDiff[xLen]) begin
                // restore
                acc <= {remShift[xLen-1:0], acc[xLen-2:0], 1'b0};
            end else begin
                acc <= {remDiff[xLen-1:0], acc[xLen-2:0], 1'b1};
            end
        end
    end

endmodule

/* hdl/resultMerge.sv */
// ============================================================
// merges both unit responses into one output register
// ALU response wins; order holds since issue stalls on mul/div
// ============================================================
module resultMerge #(
    parameter int xLen = execPkg::xLen
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            outReady,
    output logic            inReady,
    output logic            outValid,
    output logic [xLen-1:0] outResult,
    output logic            outBranchTaken,
    output logic [xLen-1:0] outNextPc,
    input  logic            aluReady,
    input  logic            mulDivReady,
    unitRespIf.merge        aluResp,
    unitRespIf.merge        mulDivResp
);

    logic load;

    // output register empty or leaving
    assign load = !outValid || outReady;

    assign aluResp.ready = load;
    assign mulDivResp.ready = load && !aluResp.valid;

    // no issue while either unit is full
    assign inReady = aluReady && mulDivReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= aluResp.valid || mulDivResp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (aluResp.valid) begin
                outResult <= aluResp.data;
                outBranchTaken <= aluResp.taken;
                outNextPc <= aluResp.target;
            end else if (mulDivResp.valid) begin
                outResult <= mulDivResp.data;
                outBranchTaken <= mulDivResp.taken;
                outNextPc <= mulDivResp.target;
            end
        end
    end

endmodule

/* hdl/unitRespIf.sv */
// ============================================================
// one response from an execute unit to the merge block
// moves on an edge where valid and ready are both high
// ============================================================
interface unitRespIf #(
    parameter int xLen = execPkg::xLen
) ();

    logic            valid;
    logic            ready;
    logic [xLen-1:0] data;
    logic            taken;
    logic [xLen-1:0] target;

    // producer side
    modport unit (
        output valid,
        output data,
        output taken,
        output target,
        input  ready
    );

    // consumer side
    modport merge (
        input  valid,
        input  data,
        input  taken,
        input  target,
        output ready
    );

endinterface

/* sim/executeTb.sv */
// ============================================================
// directed and LFSR-random testbench for the execute stage
// assumes xLen of 32; a fixed seed makes every run identical
// ============================================================
module executeTb;

    localparam int xLen = 32;
    localparam int mdSteps = 32;
    localparam int aluLatency = 2;
    localparam int mdLatency = mdSteps + 2;
    localparam int aluOps = 12 * 2 * 4 * 4;
    localparam int brOps = 8 * 5;
    localparam int mdOps = 8 * 6;
    localparam int mixOps = 200;
    localparam int latOps = 4;
    localparam int totalOps = aluOps + brOps + mdOps + mixOps + latOps;
    localparam int cycleLimit = totalOps * 40 + 500;
    localparam logic [31:0] seed = 32'h5cf8_decb;
    localparam logic [31:0] minInt = 32'h8000_0000;

    typedef struct packed {
        execPkg::execOp  op;
        logic [xLen-1:0] result;
        logic            taken;
        logic [xLen-1:0] nextPc;
        logic            isMd;
        logic            timed;
        logic [31:0]     acceptCycle;
    } expectT;

    logic               clk;
    logic               arstN;
    logic               inValid;
    logic               inReady;
    execPkg::execOp     inOp;
    execPkg::branchType inBranch;
    logic               inUseImm;
    logic [xLen-1:0]    inPc;
    logic [xLen-1:0]    inSrc1;
    logic [xLen-1:0]    inSrc2;
    logic [xLen-1:0]    inImm;
    logic               outValid;
    logic               outReady;
    logic [xLen-1:0]    outResult;
    logic               outBranchTaken;
    logic [xLen-1:0]    outNextPc;

    expectT      expQ [$];
    logic [31:0] stimState = seed;
    logic [31:0] readyState = seed;
    logic        randomReady = 1'b0;
    int          cycleCount = 0;
    int          errCount = 0;
    int          checkCount = 0;
    int          errMark = 0;
    int          chkMark = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    execPkg::execOp aluList [12] = '{execPkg::opAdd, execPkg::opSub, execPkg::opSll,
        execPkg::opSlt, execPkg::opSltu, execPkg::opXor, execPkg::opSrl, execPkg::opSra,
        execPkg::opOr, execPkg::opAnd, execPkg::opClear1, execPkg::opClear2};
    execPkg::execOp mdList [8] = '{execPkg::opMul, execPkg::opMulh, execPkg::opMulhsu,
        execPkg::opMulhu, execPkg::opDiv, execPkg::opDivu, execPkg::opRem, execPkg::opRemu};
    // equal, signed less, signed greater, unsigned wrap both ways
    logic [31:0] brA [5] = '{32'd5, 32'hffff_fffd, 32'd7, 32'd1, 32'hffff_ffff};
    logic [31:0] brB [5] = '{32'd5, 32'd7, 32'hffff_fffd, 32'hffff_ffff, 32'd1};
    // random, divide by zero, overflow, min by one, minus one squared, zeros
    logic [31:0] mdA [6] = '{32'd0, 32'd0, minInt, minInt, 32'hffff_ffff, 32'd0};
    logic [31:0] mdB [6] = '{32'd0, 32'd0, 32'hffff_ffff, 32'd1, 32'hffff_ffff, 32'd0};

    executeTop #(.xLen(xLen)) UUT (
        .clk            (clk),
        .arstN          (arstN),
        .inValid        (inValid),
        .inReady        (inReady),
        .inOp           (inOp),
        .inBranch       (inBranch),
        .inUseImm       (inUseImm),
        .inPc           (inPc),
        .inSrc1         (inSrc1),
        .inSrc2         (inSrc2),
        .inImm          (inImm),
        .outValid       (outValid),
        .outReady       (outReady),
        .outResult      (outResult),
        .outBranchTaken (outBranchTaken),
        .outNextPc      (outNextPc)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] stimBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stimState = lfsrNext(stimState);
            v = {v[30:0], stimState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] edgeVal(input int k);
        case (k)
            0:       return 32'd0;
            1:       return 32'hffff_ffff;
            2:       return minInt;
            default: return stimBits(32);
        endcase
    endfunction

    function automatic expectT refModel(input execPkg::execOp op,
            input execPkg::branchType br, input logic useImm, input logic [xLen-1:0] pc,
            input logic [xLen-1:0] s1, input logic [xLen-1:0] s2, input logic [xLen-1:0] imm);
        expectT          e;
        logic [xLen-1:0] b;
        logic [4:0]      sh;
        logic [63:0]     prod;
        logic            cmp;
        e = '0;
        e.op = op;
        b = useImm ? imm : s2;
        sh = b[4:0];
        prod = '0;
        cmp = 1'b0;
        case (op)
            execPkg::opAdd:    e.result = s1 + b;
            execPkg::opSub:    e.result = s1 - b;
            execPkg::opSll:    e.result = s1 << sh;
            execPkg::opSlt:    e.result = ($signed(s1) < $signed(b)) ? 32'd1 : 32'd0;
            execPkg::opSltu:   e.result = (s1 < b) ? 32'd1 : 32'd0;
            execPkg::opXor:    e.result = s1 ^ b;
            execPkg::opSrl:    e.result = s1 >> sh;
            execPkg::opSra:    e.result = $unsigned($signed(s1) >>> sh);
            execPkg::opOr:     e.result = s1 | b;
            execPkg::opAnd:    e.result = s1 & b;
            execPkg::opClear1: e.result = s1 & ~b;
            execPkg::opClear2: e.result = ~s1 & b;
            execPkg::opMul:    e.result = s1 * s2;
            execPkg::opMulh: begin
                prod = {{32{s1[31]}}, s1} * {{32{s2[31]}}, s2};
                e.result = prod[63:32];
            end
            execPkg::opMulhsu: begin
                prod = {{32{s1[31]}}, s1} * {32'd0, s2};
                e.result = prod[63:32];
            end
            execPkg::opMulhu: begin
                prod = {32'd0, s1} * {32'd0, s2};
                e.result = prod[63:32];
            end
            execPkg::opDiv: begin
                if (s2 == 0)
                    e.result = '1;
                else if (s1 == minInt && s2 == '1)
                    e.result = minInt;
                else
                    e.result = $signed(s1) / $signed(s2);
            end
            execPkg::opDivu:   e.result = (s2 == 0) ? '1 : s1 / s2;
            execPkg::opRem: begin
                if (s2 == 0)
                    e.result = s1;
                else if (s1 == minInt && s2 == '1)
                    e.result = '0;
                else
                    e.result = $signed(s1) % $signed(s2);
            end
            execPkg::opRemu:   e.result = (s2 == 0) ? s1 : s1 % s2;
            default:           e.result = '0;
        endcase
        e.isMd = op inside {execPkg::opMul, execPkg::opMulh, execPkg::opMulhsu,
                            execPkg::opMulhu, execPkg::opDiv, execPkg::opDivu,
                            execPkg::opRem, execPkg::opRemu};
        // mul/div never branches
        if (!e.isMd) begin
            case (br)
                execPkg::brEq:     cmp = (s1 == s2);
                execPkg::brNe:     cmp = (s1 != s2);
                execPkg::brLt:     cmp = ($signed(s1) < $signed(s2));
                execPkg::brGe:     cmp = ($signed(s1) >= $signed(s2));
                execPkg::brLtu:    cmp = (s1 < s2);
                execPkg::brGeu:    cmp = (s1 >= s2);
                execPkg::brAlways: cmp = 1'b1;
                default:           cmp = 1'b0;
            endcase
            e.taken = (br != execPkg::brNone) && cmp;
        end
        e.nextPc = e.taken ? pc + imm : pc + 32'd4;
        return e;
    endfunction

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run hung after %0d cycles", cycleCount);
            $display("TESTS FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : readyDrive
        logic hiBit;
        readyState = lfsrNext(readyState);
        hiBit = readyState[0];
        readyState = lfsrNext(readyState);
        // high three cycles out of four
        outReady = randomReady ? (hiBit | readyState[0]) : 1'b1;
    end

    always @(posedge clk) begin : scoreboard
        expectT e;
        int     lat;
        if (arstN) begin
            if (inValid && inReady) begin
                e = refModel(inOp, inBranch, inUseImm, inPc, inSrc1, inSrc2, inImm);
                e.timed = !randomReady;
                e.acceptCycle = cycleCount;
                expQ.push_back(e);
            end
            if (outValid && outReady) begin
                assert (expQ.size() != 0) else begin
                    $display("output transfer at %0t with no operation pending", $time);
                    errCount++;
                end
                if (expQ.size() != 0) begin
                    e = expQ.pop_front();
                    lat = cycleCount - e.acceptCycle;
                    checkCount++;
                    assert (outResult == e.result) else begin
                        $display("FAILED %0t: %s result %h, expected %h",
                                 $time, e.op.name(), outResult, e.result);
                        errCount++;
                    end
                    assert (outBranchTaken == e.taken) else begin
                        $display("FAILED %0t: %s taken %b, expected %b",
                                 $time, e.op.name(), outBranchTaken, e.taken);
                        errCount++;
                    end
                    assert (outNextPc == e.nextPc) else begin
                        $display("FAILED %0t: %s next pc %h, expected %h",
                                 $time, e.op.name(), outNextPc, e.nextPc);
                        errCount++;
                    end
                    assert (!e.timed || lat == (e.isMd ? mdLatency : aluLatency)) else begin
                        $display("FAILED %0t: %s latency %0d cycles, expected %0d",
                                 $time, e.op.name(), lat, e.isMd ? mdLatency : aluLatency);
                        errCount++;
                    end
                end
            end
        end
    end

    // call on a falling edge; returns on the falling edge after the accept
    task automatic issueOp(input execPkg::execOp op, input execPkg::branchType br,
            input logic useImm, input logic [xLen-1:0] pc, input logic [xLen-1:0] s1,
            input logic [xLen-1:0] s2, input logic [xLen-1:0] imm);
        inValid = 1'b1;
        inOp = op;
        inBranch = br;
        inUseImm = useImm;
        inPc = pc;
        inSrc1 = s1;
        inSrc2 = s2;
        inImm = imm;
        @(posedge clk);
        while (!inReady) @(posedge clk);
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic endTest(input string name);
        int errs;
        while (expQ.size() != 0) @(negedge clk);
        errs = errCount - errMark;
        testsRun++;
        if (errs != 0)
            testsFailed++;
        $display("test %s: %0d checks, %0d errors", name, checkCount - chkMark, errs);
        errMark = errCount;
        chkMark = checkCount;
    endtask

    initial begin : stimulus
        logic [xLen-1:0] a;
        logic [xLen-1:0] b;
        execPkg::execOp  op;
        clk = 1'b0;
        arstN = 1'b0;
        inValid = 1'b0;
        inOp = execPkg::opAdd;
        inBranch = execPkg::brNone;
        inUseImm = 1'b0;
        inPc = '0;
        inSrc1 = '0;
        inSrc2 = '0;
        inImm = '0;
        outReady = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        assert (outValid === 1'b0) else begin
            $display("FAILED %0t: outValid %b after reset, expected 0", $time, outValid);
            errCount++;
        end
        assert (inReady === 1'b1) else begin
            $display("FAILED %0t: inReady %b after reset, expected 1", $time, inReady);
            errCount++;
        end
        checkCount += 2;
        endTest("reset");

        for (int o = 0; o < 12; o++) begin
            for (int u = 0; u < 2; u++) begin
                for (int i = 0; i < 4; i++) begin
                    for (int j = 0; j < 4; j++) begin
                        a = edgeVal(i);
                        b = edgeVal(j);
                        if (u == 0)
                            issueOp(aluList[o], execPkg::brNone, 1'b0,
                                    stimBits(32) & ~32'h3, a, b, stimBits(32));
                        else
                            issueOp(aluList[o], execPkg::brNone, 1'b1,
                                    stimBits(32) & ~32'h3, a, stimBits(32), b);
                    end
                end
            end
        end
        endTest("alu");

        for (int t = 0; t < 8; t++) begin
            for (int p = 0; p < 5; p++) begin
                issueOp(aluList[stimBits(4) % 12], execPkg::branchType'(t), 1'b0,
                        stimBits(32) & ~32'h3, brA[p], brB[p], stimBits(32) & ~32'h1);
            end
        end
        endTest("branch");

        for (int m = 0; m < 8; m++) begin
            for (int p = 0; p < 6; p++) begin
                // pair 0 is fully random, pair 1 a random dividend over zero
                a = (p < 2) ? stimBits(32) : mdA[p];
                b = (p == 0) ? stimBits(32) : mdB[p];
                issueOp(mdList[m], execPkg::branchType'(stimBits(3)), stimBits(1),
                        stimBits(32) & ~32'h3, a, b, stimBits(32));
            end
        end
        endTest("muldiv");

        randomReady = 1'b1;
        for (int n = 0; n < mixOps; n++) begin
            if (stimBits(2) == 0)
                op = mdList[stimBits(3)];
            else
                op = aluList[stimBits(4) % 12];
            issueOp(op, execPkg::branchType'(stimBits(3)), stimBits(1),
                    stimBits(32) & ~32'h3, edgeVal(stimBits(3)), edgeVal(stimBits(3)),
                    stimBits(32));
            // occasional idle cycle
            if (stimBits(3) == 0)
                @(negedge clk);
        end
        endTest("mixed");

        randomReady = 1'b0;
        @(negedge clk);
        issueOp(execPkg::opMul, execPkg::brNone, 1'b0, 32'h100, stimBits(32), stimBits(32), 0);
        issueOp(execPkg::opAdd, execPkg::brEq, 1'b0, 32'h104, 32'd3, 32'd3, 32'h40);
        issueOp(execPkg::opDiv, execPkg::brNone, 1'b0, 32'h108, stimBits(32), 32'd7, 0);
        issueOp(execPkg::opXor, execPkg::brNone, 1'b1, 32'h10c, stimBits(32), 0, 32'hff);
        endTest("latency");

        // bound assertion failures count as errors too
        errCount += UUT.props.assertFails;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/executeTop_props.sv */
// ============================================================
// bound checks on the execute stage output and issue control
// reaches into the mul/div FSM state by hierarchy
// ============================================================
module executeTopProps #(
    parameter int xLen = execPkg::xLen
) (
    input logic                clk,
    input logic                arstN,
    input logic                inReady,
    input logic                outValid,
    input logic                outReady,
    input logic [xLen-1:0]     outResult,
    input logic                outBranchTaken,
    input logic [xLen-1:0]     outNextPc,
    input execPkg::mulDivState mdState
);

    // failures seen so far
    int assertFails = 0;

    // stalled output holds its value
    outStable: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outResult)
            && $stable(outBranchTaken) && $stable(outNextPc))
        else begin
            $error("output changed while stalled");
            assertFails++;
        end

    // no issue while a mul/div op is in flight
    noIssueBusy: assert property (@(posedge clk) disable iff (!arstN)
        mdState != execPkg::sIdle |-> !inReady)
        else begin
            $error("inReady high while mul/div unit busy");
            assertFails++;
        end

    resetClear: assert property (@(posedge clk) $rose(arstN) |-> !outValid)
        else begin
            $error("outValid high right after reset");
            assertFails++;
        end

endmodule

bind executeTop executeTopProps #(.xLen(xLen)) props (
    .clk            (clk),
    .arstN          (arstN),
    .inReady        (inReady),
    .outValid       (outValid),
    .outReady       (outReady),
    .outResult      (outResult),
    .outBranchTaken (outBranchTaken),
    .outNextPc      (outNextPc),
    .mdState        (mulDiv.state)
);

/* sources.f */
hdl/execPkg.sv
hdl/unitRespIf.sv
hdl/aluBranchUnit.sv
hdl/mulDivUnit.sv
hdl/resultMerge.sv
hdl/executeTop.sv
sim/executeTop_props.sv
sim/executeTb.sv
